/* common/h80_pkg.sv */
package h80_pkg;

   localparam int default_data_width = 16;
   localparam int default_addr_width = 16;
   localparam int num_regs = 16;
   localparam int num_flags = 4;

   typedef logic [3:0] reg_num_t;
   typedef logic [15:0] ins_t;   // always the low half of a fetched word

   // codes follow the tttn command field of the memory instructions
   typedef enum logic [2:0] {
      cmd_none    = 3'b000,
      cmd_read_w  = 3'b010,
      cmd_write_w = 3'b101
   } bus_cmd_t;

   localparam int flag_carry = 0;
   localparam int flag_zero = 1;
   localparam int flag_sign = 2;
   localparam int flag_overflow = 3;

   // flag select for jumps, one past the real flags means always taken
   typedef logic [2:0] cond_sel_t;
   localparam cond_sel_t cond_always = 3'(num_flags);

   // three-register opcodes minus 8
   typedef enum logic [3:0] {
      op_add = 4'd0,
      op_sub = 4'd1,
      op_mul = 4'd2,
      op_div = 4'd3,
      op_and = 4'd4,
      op_or  = 4'd5,
      op_xor = 4'd6,
      op_cp  = 4'd7
   } alu_op_t;

   typedef enum logic [2:0] {
      cls_nop      = 3'd0,
      cls_halt     = 3'd1,
      cls_alu      = 3'd2,
      cls_load_imm = 3'd3,
      cls_jump     = 3'd4,
      cls_mem      = 3'd5
   } ins_class_t;

   // fixed words and top nibbles
   localparam ins_t ins_nop = 16'h0000;
   localparam ins_t ins_halt = 16'h0001;
   localparam logic [3:0] opc_ld_zx = 4'h1;   // reg[d] = n, zero extended
   localparam logic [3:0] opc_ld_sx = 4'h2;   // reg[d] = n, sign extended
   localparam logic [3:0] opc_mem = 4'h3;     // 3 tttn_aaaa_bbbb

endpackage

/* rtl/h80_regfile.sv */
module h80_regfile #(
   parameter int data_width = h80_pkg::default_data_width
) (
   input  logic                  clk,
   input  logic                  reset,
   input  h80_pkg::reg_num_t     rd_num_a,
   input  h80_pkg::reg_num_t     rd_num_b,
   output logic [data_width-1:0] rd_data_a,
   output logic [data_width-1:0] rd_data_b,
   input  logic                  wr_en,
   input  h80_pkg::reg_num_t     wr_num,
   input  logic [data_width-1:0] wr_data
);
   import h80_pkg::*;

   logic [data_width-1:0] regs [num_regs];

   // asynchronous read, a write shows up after the edge
   assign rd_data_a = regs[rd_num_a];
   assign rd_data_b = regs[rd_num_b];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;   // all general registers start at zero
         end
      end else if (wr_en) begin
         regs[wr_num] <= wr_data;
      end
   end

endmodule

/* rtl/h80_sequencer.sv */
module h80_sequencer #(
   parameter int data_width = h80_pkg::default_data_width,
   parameter int addr_width = h80_pkg::default_addr_width
) (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           bus_wait_n,
   input  logic [data_width-1:0]          bus_rd_data,
   output h80_pkg::ins_t                  ins,
   input  h80_pkg::ins_class_t            ins_class,
   input  h80_pkg::alu_op_t               alu_op,
   input  h80_pkg::reg_num_t              num_dst,
   input  logic [7:0]                     imm,
   input  logic                           use_imm,
   input  logic                           sign_imm,
   input  h80_pkg::cond_sel_t             cond_flag,
   input  logic                           cond_true,
   input  logic                           jump_relative,
   input  logic                           mem_write,
   input  logic [data_width-1:0]          operand_a,
   input  logic [data_width-1:0]          operand_b,
   input  logic [data_width-1:0]          alu_result,
   input  logic [h80_pkg::num_flags-1:0]  alu_flags,
   output logic [data_width-1:0]          alu_b,
   output logic                           reg_wr_en,
   output h80_pkg::reg_num_t              reg_wr_num,
   output logic [data_width-1:0]          reg_wr_data,
   output logic                           carry_out,
   output logic                           mreq_n,
   output h80_pkg::bus_cmd_t              bus_cmd,
   output logic [addr_width-1:0]          bus_addr,
   output logic [data_width-1:0]          bus_wr_data,
   output logic                           halted
);
   import h80_pkg::*;

   typedef enum logic [1:0] {st_start, st_fetch, st_data} state_t;

   state_t state;
   logic [data_width-1:0] pc;          // address of the instruction being fetched
   logic [num_flags-1:0] flags;
   reg_num_t pend_num;                 // destination of an outstanding read
   logic done;
   logic fetch_done;
   logic data_done;
   logic taken;
   logic [num_flags:0] cond_vec;
   logic [data_width-1:0] imm_ext;
   logic [data_width-1:0] jump_target;
   logic [data_width-1:0] next_pc;

   assign ins = ins_t'(bus_rd_data[15:0]);
   assign done = bus_wait_n && (bus_cmd != cmd_none);   // transaction completes this edge
   assign fetch_done = done && (state == st_fetch);
   assign data_done = done && (state == st_data);
   assign mreq_n = (bus_cmd == cmd_none);
   assign carry_out = flags[flag_carry];

   assign imm_ext = sign_imm ? {{(data_width-8){imm[7]}}, imm} : {{(data_width-8){1'b0}}, imm};
   assign alu_b = use_imm ? imm_ext : operand_b;

   // top entry is the always-true pseudo flag
   assign cond_vec = {1'b1, flags};
   assign taken = (ins_class == cls_jump) && (cond_vec[cond_flag] == cond_true);
   assign jump_target = jump_relative ? pc + operand_b : operand_b;
   assign next_pc = taken ? jump_target : pc + data_width'(2);

   always_comb begin
      reg_wr_en = 1'b0;
      reg_wr_num = num_dst;
      reg_wr_data = alu_result;
      if (data_done) begin
         reg_wr_en = (bus_cmd == cmd_read_w);
         reg_wr_num = pend_num;
         reg_wr_data = bus_rd_data;
      end else if (fetch_done) begin
         if (ins_class == cls_alu) begin
            reg_wr_en = (alu_op != op_cp);   // CP only touches flags
         end else if (ins_class == cls_load_imm) begin
            reg_wr_en = 1'b1;
            reg_wr_data = imm_ext;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_start;
         pc <= '0;
         flags <= '0;
         halted <= 1'b0;
         bus_cmd <= cmd_none;
      end else begin
         case (state)
            st_start: begin
               bus_cmd <= cmd_read_w;
               bus_addr <= addr_width'(pc);
               state <= st_fetch;
            end
            st_fetch: begin
               if (fetch_done) begin
                  pc <= next_pc;
                  if (ins_class == cls_alu) begin
                     flags <= alu_flags;
                  end
                  if (ins_class == cls_halt) begin
                     halted <= 1'b1;
                     bus_cmd <= cmd_none;   // nothing completes from here on
                  end else if (ins_class == cls_mem) begin
                     bus_cmd <= mem_write ? cmd_write_w : cmd_read_w;
                     bus_addr <= addr_width'(operand_b);
                     bus_wr_data <= operand_a;
                     pend_num <= num_dst;
                     state <= st_data;
                  end else begin
                     bus_cmd <= cmd_read_w;
                     bus_addr <= addr_width'(next_pc);
                  end
               end
            end
            st_data: begin
               if (data_done) begin
                  bus_cmd <= cmd_read_w;
                  bus_addr <= addr_width'(pc);   // pc already advanced at execute
                  state <= st_fetch;
               end
            end
            default: state <= st_start;
         endcase
      end
   end

endmodule

/* exec/h80_decoder.sv */
module h80_decoder (
   input  h80_pkg::ins_t       ins,
   output h80_pkg::ins_class_t ins_class,
   output h80_pkg::alu_op_t    alu_op,
   output h80_pkg::reg_num_t   num_a,
   output h80_pkg::reg_num_t   num_b,
   output h80_pkg::reg_num_t   num_dst,
   output logic [7:0]          imm,
   output logic                use_imm,
   output logic                sign_imm,
   output h80_pkg::cond_sel_t  cond_flag,
   output logic                cond_true,
   output logic                jump_relative,
   output logic                mem_write
);
   import h80_pkg::*;

   logic [2:0] mem_cmd;

   assign mem_cmd = ins[11:9];

   always_comb begin
      // defaults fit the three-register layout
      ins_class = cls_nop;
      alu_op = op_add;
      num_a = ins[7:4];
      num_b = ins[3:0];
      num_dst = ins[11:8];
      imm = ins[7:0];
      use_imm = 1'b0;
      sign_imm = 1'b0;
      cond_flag = cond_always;   // unconditional unless a flag is named
      cond_true = 1'b1;
      jump_relative = 1'b0;
      mem_write = 1'b0;

      casez (ins)
         ins_nop: ins_class = cls_nop;
         ins_halt: ins_class = cls_halt;
         16'b0000_0001_111?_????: begin   // JP R / JR R
            ins_class = cls_jump;
            jump_relative = ins[4];
         end
         16'b0000_0011_????_????: begin   // 03 mm ff rrrr
            ins_class = cls_jump;
            jump_relative = ins[7];
            cond_true = ins[6];
            cond_flag = cond_sel_t'(ins[5:4]);
         end
         16'b0000_100?_????_????: begin   // ADD/SUB R, n
            ins_class = cls_alu;
            alu_op = ins[8] ? op_sub : op_add;
            num_dst = ins[7:4];
            imm = {4'b0000, ins[3:0]};
            use_imm = 1'b1;
         end
         {opc_ld_zx, 12'b????_????_????},
         {opc_ld_sx, 12'b????_????_????}: begin
            ins_class = cls_load_imm;
            sign_imm = (ins[15:12] == opc_ld_sx);
         end
         {opc_mem, 12'b????_????_????}: begin
            // only word commands on the memory bus are kept
            if (!ins[8] && (mem_cmd == cmd_read_w || mem_cmd == cmd_write_w)) begin
               ins_class = cls_mem;
               num_dst = ins[7:4];
               mem_write = (mem_cmd == cmd_write_w);
            end
         end
         16'b1???_????_????_????: begin   // 8..F dddd aaaa bbbb
            ins_class = cls_alu;
            alu_op = alu_op_t'({1'b0, ins[14:12]});
         end
         default: ins_class = cls_nop;   // reserved words run as NOP
      endcase
   end

endmodule

/* exec/h80_alu.sv */
module h80_alu #(
   parameter int data_width = h80_pkg::default_data_width
) (
   input  h80_pkg::alu_op_t               op,
   input  logic [data_width-1:0]          a,
   input  logic [data_width-1:0]          b,
   input  logic                           carry_in,
   output logic [data_width-1:0]          result,
   output logic [h80_pkg::num_flags-1:0]  flags
);
   import h80_pkg::*;

   localparam int sb = data_width - 1;   // sign bit

   logic [data_width:0] ext_a;
   logic [data_width:0] ext_b;
   logic [data_width:0] wide;            // result plus carry bit

   assign ext_a = {1'b0, a};
   assign ext_b = {1'b0, b};

   always_comb begin
      case (op)
         op_add: wide = ext_a + ext_b;
         op_sub,
         op_cp: wide = ext_a - ext_b;     // borrow lands in the top bit
         op_mul: wide = ext_a * ext_b;    // low bits only
         op_div: wide = (b == '0) ? '1 : ext_a / ext_b;
         op_and: wide = ext_a & ext_b;
         op_or: wide = ext_a | ext_b;
         op_xor: wide = ext_a ^ ext_b;
         default: wide = ext_a;
      endcase
   end

   assign result = wide[sb:0];

   always_comb begin
      flags = '0;
      flags[flag_sign] = result[sb];
      flags[flag_zero] = (result == '0);
      case (op)
         op_add: begin
            flags[flag_carry] = wide[data_width];
            flags[flag_overflow] = (a[sb] == b[sb]) && (a[sb] != result[sb]);
         end
         op_sub,
         op_cp: begin
            flags[flag_carry] = wide[data_width];
            flags[flag_overflow] = (a[sb] != b[sb]) && (a[sb] != result[sb]);
         end
         op_and,
         op_or,
         op_xor: flags[flag_overflow] = ~^result;   // even parity
         op_mul,
         op_div: flags[flag_overflow] = 1'b0;
         default: flags[flag_carry] = carry_in;     // undefined op keeps carry
      endcase
   end

endmodule

/* rtl/h80cpu.sv */
module h80cpu #(
   parameter int data_width = h80_pkg::default_data_width,
   parameter int addr_width = h80_pkg::default_addr_width
) (
   input  logic                  clk,
   input  logic                  reset,
   output logic                  mreq_n,
   output h80_pkg::bus_cmd_t     bus_cmd,
   output logic [addr_width-1:0] bus_addr,
   output logic [data_width-1:0] bus_wr_data,
   input  logic [data_width-1:0] bus_rd_data,
   input  logic                  bus_wait_n,
   output logic                  halted
);
   import h80_pkg::*;

   ins_t ins;
   ins_class_t ins_class;
   alu_op_t alu_op;
   reg_num_t num_a;
   reg_num_t num_b;
   reg_num_t num_dst;
   logic [7:0] imm;
   logic use_imm;
   logic sign_imm;
   cond_sel_t cond_flag;
   logic cond_true;
   logic jump_relative;
   logic mem_write;
   logic [data_width-1:0] operand_a;
   logic [data_width-1:0] operand_b;
   logic [data_width-1:0] alu_b;
   logic [data_width-1:0] alu_result;
   logic [num_flags-1:0] alu_flags;
   logic carry_out;
   logic reg_wr_en;
   reg_num_t reg_wr_num;
   logic [data_width-1:0] reg_wr_data;

   h80_sequencer #(.data_width(data_width), .addr_width(addr_width)) u_seq (
      .clk(clk), .reset(reset), .bus_wait_n(bus_wait_n), .bus_rd_data(bus_rd_data),
      .ins(ins), .ins_class(ins_class), .alu_op(alu_op), .num_dst(num_dst), .imm(imm),
      .use_imm(use_imm), .sign_imm(sign_imm), .cond_flag(cond_flag), .cond_true(cond_true),
      .jump_relative(jump_relative), .mem_write(mem_write), .operand_a(operand_a),
      .operand_b(operand_b), .alu_result(alu_result), .alu_flags(alu_flags), .alu_b(alu_b),
      .reg_wr_en(reg_wr_en), .reg_wr_num(reg_wr_num), .reg_wr_data(reg_wr_data),
      .carry_out(carry_out), .mreq_n(mreq_n), .bus_cmd(bus_cmd), .bus_addr(bus_addr),
      .bus_wr_data(bus_wr_data), .halted(halted)
   );

   h80_decoder u_dec (
      .ins(ins), .ins_class(ins_class), .alu_op(alu_op), .num_a(num_a), .num_b(num_b),
      .num_dst(num_dst), .imm(imm), .use_imm(use_imm), .sign_imm(sign_imm),
      .cond_flag(cond_flag), .cond_true(cond_true), .jump_relative(jump_relative),
      .mem_write(mem_write)
   );

   h80_regfile #(.data_width(data_width)) u_regs (
      .clk(clk), .reset(reset), .rd_num_a(num_a), .rd_num_b(num_b),
      .rd_data_a(operand_a), .rd_data_b(operand_b),
      .wr_en(reg_wr_en), .wr_num(reg_wr_num), .wr_data(reg_wr_data)
   );

   h80_alu #(.data_width(data_width)) u_alu (
      .op(alu_op), .a(operand_a), .b(alu_b), .carry_in(carry_out),
      .result(alu_result), .flags(alu_flags)
   );

endmodule

/* verif/h80_clock_gen.sv */
module h80_clock_gen #(
   parameter int half_period = 5,
   parameter int reset_cycles = 16
) (
   output logic clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      #1 reset = 1'b0;   // released just after an edge
   end

endmodule

/* verif/h80_checker.sv */
module h80_checker (
   input  logic              clk,
   input  logic              reset,
   input  logic              mreq_n,
   input  h80_pkg::bus_cmd_t bus_cmd,
   input  logic [15:0]       bus_addr,
   input  logic [15:0]       bus_wr_data,
   input  logic [15:0]       bus_rd_data,
   input  logic              bus_wait_n,
   input  logic              halted,
   output int                error_count,
   output int                check_count,
   output logic              done
);
   timeunit 1ns;
   timeprecision 100ps;
   import h80_pkg::*;

   logic [15:0] m_regs [16];
   logic [15:0] m_pc;
   logic [3:0] m_flags;     // ov, sign, zero, carry
   logic m_halted;
   logic m_in_data;         // a data transaction is expected next
   logic m_wr;
   logic [3:0] m_dst;
   logic [15:0] m_addr;
   logic [15:0] m_data;
   int halt_cycles;

   // expected {flags, result} for one ALU operation
   function automatic logic [19:0] alu_ref(input logic [2:0] op, input logic [15:0] a,
                                           input logic [15:0] b);
      logic [16:0] wide;
      logic [15:0] r;
      logic c;
      logic v;
      c = 1'b0;
      v = 1'b0;
      r = 16'h0000;
      case (op)
         3'd0: begin
            wide = {1'b0, a} + {1'b0, b};
            r = wide[15:0];
            c = wide[16];
            v = (a[15] == b[15]) && (r[15] != a[15]);
         end
         3'd1, 3'd7: begin
            r = a - b;
            c = (a < b);   // borrow
            v = (a[15] != b[15]) && (r[15] != a[15]);
         end
         3'd2: r = a * b;
         3'd3: r = (b == 16'h0000) ? 16'hffff : a / b;
         3'd4: begin
            r = a & b;
            v = ~^r;
         end
         3'd5: begin
            r = a | b;
            v = ~^r;
         end
         default: begin
            r = a ^ b;
            v = ~^r;
         end
      endcase
      return {v, r[15], (r == 16'h0000), c, r};
   endfunction

   // one instruction on the model state
   function void exec_ins(input logic [15:0] w);
      logic [19:0] res;
      logic taken;
      logic [15:0] target;
      taken = 1'b0;
      target = 16'h0000;
      if (w == 16'h0001) begin
         m_halted = 1'b1;
      end else if (w[15:5] == 11'b0000_0001_111) begin
         taken = 1'b1;
         target = w[4] ? m_pc + m_regs[w[3:0]] : m_regs[w[3:0]];
      end else if (w[15:8] == 8'h03) begin
         taken = (m_flags[w[5:4]] == w[6]);
         target = w[7] ? m_pc + m_regs[w[3:0]] : m_regs[w[3:0]];
      end else if (w[15:9] == 7'b0000_100) begin
         res = alu_ref({2'b00, w[8]}, m_regs[w[7:4]], {12'h000, w[3:0]});
         m_regs[w[7:4]] = res[15:0];
         m_flags = res[19:16];
      end else if (w[15:12] == 4'h1) begin
         m_regs[w[11:8]] = {8'h00, w[7:0]};
      end else if (w[15:12] == 4'h2) begin
         m_regs[w[11:8]] = {{8{w[7]}}, w[7:0]};
      end else if (w[15:12] == 4'h3 && !w[8] && (w[11:9] == 3'b010 || w[11:9] == 3'b101)) begin
         m_in_data = 1'b1;
         m_wr = (w[11:9] == 3'b101);
         m_dst = w[7:4];
         m_addr = m_regs[w[3:0]];
         m_data = m_regs[w[7:4]];
      end else if (w[15]) begin
         res = alu_ref(w[14:12], m_regs[w[7:4]], m_regs[w[3:0]]);
         if (w[14:12] != 3'd7) m_regs[w[11:8]] = res[15:0];   // CP keeps registers
         m_flags = res[19:16];
      end
      if (!m_halted) m_pc = taken ? target : m_pc + 16'd2;
   endfunction

   task automatic report_mismatch(input string msg);
      error_count++;
      $display("FAILED at %0t: %s", $time, msg);
   endtask

   assign done = m_halted && (halt_cycles >= 8);

   initial begin
      error_count = 0;
      check_count = 0;
   end

   // nothing may be presented during reset
   always @(negedge clk) begin
      if (reset && (mreq_n !== 1'b1 || halted !== 1'b0)) begin
         report_mismatch("bus active or halted set during reset");
      end
   end

   always @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 16; i++) m_regs[i] = 16'h0000;
         m_pc = 16'h0000;
         m_flags = 4'h0;
         m_halted = 1'b0;
         m_in_data = 1'b0;
         m_wr = 1'b0;
         halt_cycles = 0;
      end else begin
         if (halted !== m_halted) begin
            report_mismatch($sformatf("halted %b, model %b", halted, m_halted));
         end
         if (m_halted) begin
            halt_cycles++;
            if (mreq_n !== 1'b1) report_mismatch("bus command after HALT");
         end else if (mreq_n === 1'b0 && bus_wait_n === 1'b1) begin
            check_count++;
            if (!m_in_data) begin
               if (bus_cmd !== cmd_read_w || bus_addr !== m_pc) begin
                  report_mismatch($sformatf("fetch cmd %0d addr %h, expected addr %h",
                                            bus_cmd, bus_addr, m_pc));
               end
               exec_ins(bus_rd_data);
            end else if (m_wr) begin
               if (bus_cmd !== cmd_write_w || bus_addr !== m_addr || bus_wr_data !== m_data) begin
                  report_mismatch($sformatf("write %h to %h, expected %h to %h",
                                            bus_wr_data, bus_addr, m_data, m_addr));
               end
               m_in_data = 1'b0;
            end else begin
               if (bus_cmd !== cmd_read_w || bus_addr !== m_addr) begin
                  report_mismatch($sformatf("read addr %h, expected %h", bus_addr, m_addr));
               end
               m_regs[m_dst] = bus_rd_data;
               m_in_data = 1'b0;
            end
         end
      end
   end

endmodule

/* verif/h80_tb.sv */
module h80_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import h80_pkg::*;

   localparam int reset_cycles = 16;
   localparam int max_ins = 200;
   localparam int cycle_limit = reset_cycles + max_ins * 2 * 5;   // two transactions of 4 cycles plus slack

   localparam logic [15:0] program_words [59] = '{
      16'h0000, 16'h1180, 16'h8111, 16'h3421, 16'h0812, 16'h3431, 16'h2480, 16'h1503,
      16'h2FF8, 16'h8623, 16'h9723, 16'hA823, 16'hB923, 16'hBA20, 16'hCB23, 16'hDC23,
      16'hED23, 16'h0812, 16'h3A61, 16'h0812, 16'h3A71, 16'h0812, 16'h3A81, 16'h0812,
      16'h3A91, 16'h0812, 16'h3AA1, 16'h0812, 16'h3AB1, 16'h0812, 16'h3AC1, 16'h0812,
      16'h3AD1, 16'h8224, 16'h3A21, 16'h0812, 16'h0951, 16'h039F, 16'h1E54, 16'hF023,
      16'h034E, 16'h0000, 16'h1C04, 16'h8A67, 16'h03AC, 16'h0000, 16'hED27, 16'h03BC,
      16'h0000, 16'h1B68, 16'h01EB, 16'h0001, 16'h01FC, 16'h0001, 16'h0912, 16'h3491,
      16'h0812, 16'h3A91, 16'h0001
   };

   logic clk;
   logic reset;
   logic mreq_n;
   bus_cmd_t bus_cmd;
   logic [15:0] bus_addr;
   logic [15:0] bus_wr_data;
   logic [15:0] bus_rd_data;
   logic bus_wait_n;
   logic halted;
   int error_count;
   int check_count;
   logic done;
   logic [15:0] mem [256];
   logic [31:0] rng = 32'd3816;
   logic completed;
   logic restart;
   int wait_left;
   int cycles = 0;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   h80_clock_gen #(.reset_cycles(reset_cycles)) clock_gen (.clk(clk), .reset(reset));

   h80cpu #(.data_width(16), .addr_width(16)) uut (
      .clk(clk), .reset(reset), .mreq_n(mreq_n), .bus_cmd(bus_cmd), .bus_addr(bus_addr),
      .bus_wr_data(bus_wr_data), .bus_rd_data(bus_rd_data), .bus_wait_n(bus_wait_n),
      .halted(halted)
   );

   h80_checker bus_checker (
      .clk(clk), .reset(reset), .mreq_n(mreq_n), .bus_cmd(bus_cmd), .bus_addr(bus_addr),
      .bus_wr_data(bus_wr_data), .bus_rd_data(bus_rd_data), .bus_wait_n(bus_wait_n),
      .halted(halted), .error_count(error_count), .check_count(check_count), .done(done)
   );

   assign bus_rd_data = mem[bus_addr[8:1]];   // byte address, word memory

   always @(posedge clk) begin
      if (!reset && !mreq_n && bus_wait_n && bus_cmd == cmd_write_w) begin
         mem[bus_addr[8:1]] <= bus_wr_data;
      end
   end

   // new random wait count for every transaction
   always @(posedge clk) begin
      completed = !mreq_n && bus_wait_n;
      restart = reset;
      #1;
      if (restart || completed) begin
         rng = xorshift(rng);
         wait_left = int'(rng[1:0]);
         bus_wait_n = (wait_left == 0);
      end else if (!bus_wait_n) begin
         wait_left--;
         bus_wait_n = (wait_left == 0);
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("timeout: program never halted within %0d cycles", cycle_limit);
         $display("errors: %0d, transactions checked: %0d", error_count, check_count);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      bus_wait_n = 1'b1;
      for (int i = 0; i < 256; i++) begin
         rng = xorshift(rng);
         mem[i] = rng[15:0] ^ 16'(i * 16'h0101);
      end
      for (int i = 0; i < 59; i++) mem[i] = program_words[i];
      wait (done === 1'b1);
      @(posedge clk);
      $display("errors: %0d, transactions checked: %0d", error_count, check_count);
      if (error_count == 0 && check_count > 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* filelist.f */
common/h80_pkg.sv
rtl/h80_regfile.sv
rtl/h80_sequencer.sv
exec/h80_decoder.sv
exec/h80_alu.sv
rtl/h80cpu.sv
verif/h80_clock_gen.sv
verif/h80_checker.sv
verif/h80_tb.sv
